// ==== pet_bus_cfg.svh ====
// Build constants for the PET bus-timing core
// CPU times are worst-case datasheet figures in ns, converted at the system clock rate
`ifndef PET_BUS_CFG_SVH
`define PET_BUS_CFG_SVH

`define PET_SYS_CLOCK_MHZ 64       // 64 clocks per 1 us bus cycle

`define PET_RAM_ADDR_BITS 12       // 4 KB of video/system RAM
`define PET_VIDEO_BASE    12'h000  // First screen byte

`define PET_CPU_T_BVD     30       // BE to valid data
`define PET_CPU_T_PWH     62       // Clock pulse width high
`define PET_CPU_T_DHX     10       // Data hold, read and write
`define PET_IOTX_T        11       // Bus transceiver worst-case delay

`endif

// ==== pet_bus_pkg.sv ====
// Types shared by the PET bus-timing core
// Slot numbers follow the fixed slot order of the 64-clock bus cycle
`include "pet_bus_cfg.svh"

package pet_bus_pkg;

    typedef enum logic [2:0] {
        SLOT_VIDEO_1 = 3'd0,
        SLOT_VIDEO_2 = 3'd1,
        SLOT_SPI_1   = 3'd2,
        SLOT_VIDEO_3 = 3'd3,
        SLOT_VIDEO_4 = 3'd4,
        SLOT_SPI_2   = 3'd5,
        SLOT_CPU_1   = 3'd6,
        SLOT_CPU_2   = 3'd7
    } slot_t;

    // Owner of a valid grant
    typedef enum logic {
        GRANT_VIDEO = 1'b0,
        GRANT_SPI   = 1'b1
    } grant_t;

    typedef logic [`PET_RAM_ADDR_BITS-1:0] ram_addr_t;
    typedef logic [7:0]                    byte_t;

    // Rounds up, so a derived edge never comes early
    function automatic int ns_to_cycles(input int time_ns);
        return (time_ns * `PET_SYS_CLOCK_MHZ + 999) / 1000;
    endfunction

endpackage

// ==== ram_req_if.sv ====
// Single RAM request and its response between arbiter and RAM controller
// valid is a one-cycle pulse, done follows exactly one clock later
`timescale 1ns/100ps

interface ram_req_if;
    import pet_bus_pkg::*;

    logic      valid;   // Request pulse
    ram_addr_t addr;
    logic      we;      // High for a write
    byte_t     wdata;
    byte_t     rdata;   // Read byte, held during done
    logic      done;

    modport master (
        output valid,
        output addr,
        output we,
        output wdata,
        input  rdata,
        input  done
    );

    modport slave (
        input  valid,
        input  addr,
        input  we,
        input  wdata,
        output rdata,
        output done
    );

endinterface

// ==== timing.sv ====
// Bus cycle timing: 64 clocks per cycle, eight slots of 8 clocks
// CPU edges sit at fixed counts from the start of CPU_1, derived from datasheet times
// Slot and clock enables change together, one clock after the count hits a slot boundary
`timescale 1ns/100ps
`include "pet_bus_cfg.svh"

module timing (
    input  logic                sys_clock_i,
    input  logic                reset_i,
    output logic                clk16_en_o,
    output logic                clk8_en_o,
    output logic                cpu_be_o,
    output logic                cpu_clock_o,
    output logic                cpu_data_strobe_o,
    output logic                load_sr1_o,
    output logic                load_sr2_o,
    output pet_bus_pkg::slot_t  slot_o,
    output pet_bus_pkg::grant_t grant_o,
    output logic                grant_valid_o
);
    import pet_bus_pkg::*;

    // Extra clock in each interval covers board trace delay
    localparam int BVD_CYCLES = ns_to_cycles(`PET_CPU_T_BVD + `PET_IOTX_T) + 1;
    localparam int PWH_CYCLES = ns_to_cycles(`PET_CPU_T_PWH) + 1;
    localparam int DHX_CYCLES = ns_to_cycles(`PET_CPU_T_DHX) + 1;

    localparam logic [5:0] CPU_BE_START    = 6'(int'(SLOT_CPU_1) * 8);
    localparam logic [5:0] CPU_PHI_START   = 6'(CPU_BE_START + BVD_CYCLES);
    localparam logic [5:0] CPU_PHI_END     = 6'(CPU_PHI_START + PWH_CYCLES);
    localparam logic [5:0] CPU_DATA_STROBE = 6'(CPU_PHI_END - 2);
    localparam logic [5:0] CPU_BE_END      = 6'(CPU_PHI_END + DHX_CYCLES);

    logic [5:0] cycle_count;
    slot_t      slot;
    logic       cpu_slot;
    logic       spi_slot;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            cycle_count <= '1;          // First clock after reset is count 0
            slot        <= SLOT_CPU_2;  // Wraps to VIDEO_1 on the first slot edge
            clk8_en_o   <= 1'b0;
            clk16_en_o  <= 1'b0;
        end else begin
            cycle_count <= cycle_count + 6'd1;
            clk8_en_o   <= cycle_count[2:0] == 3'b000;
            clk16_en_o  <= cycle_count[1:0] == 2'b00;
            if (cycle_count[2:0] == 3'b000) begin
                slot <= slot_t'(slot + 3'd1);
            end
        end
    end

    assign cpu_slot = (slot == SLOT_CPU_1) || (slot == SLOT_CPU_2);
    assign spi_slot = (slot == SLOT_SPI_1) || (slot == SLOT_SPI_2);

    assign slot_o        = slot;
    assign grant_o       = spi_slot ? GRANT_SPI : GRANT_VIDEO;
    assign grant_valid_o = clk8_en_o && !cpu_slot;  // CPU slots carry no grant

    assign load_sr1_o = clk8_en_o && (slot == SLOT_CPU_1);
    assign load_sr2_o = clk8_en_o && (slot == SLOT_CPU_1 || slot == SLOT_SPI_1);

    // 6502 bus phase, BE window encloses the CPU clock high pulse
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            cpu_be_o          <= 1'b0;
            cpu_clock_o       <= 1'b0;
            cpu_data_strobe_o <= 1'b0;
        end else begin
            cpu_data_strobe_o <= 1'b0;
            case (cycle_count)
                CPU_BE_START: begin
                    cpu_be_o <= 1'b1;
                end
                CPU_PHI_START: begin
                    cpu_clock_o <= 1'b1;
                end
                CPU_DATA_STROBE: begin
                    cpu_data_strobe_o <= 1'b1;  // Data settled, two clocks before fall
                end
                CPU_PHI_END: begin
                    cpu_clock_o <= 1'b0;
                end
                CPU_BE_END: begin
                    cpu_be_o <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== bus_arbiter.sv ====
// Turns each valid grant into at most one RAM request
// The SPI request is a level held until spi_done_o, served only in SPI slots
// VIDEO_2 and VIDEO_4 issue nothing since there is no character ROM
`timescale 1ns/100ps

module bus_arbiter (
    input  logic                   sys_clock_i,
    input  logic                   reset_i,
    input  pet_bus_pkg::grant_t    grant_i,
    input  logic                   grant_valid_i,
    input  pet_bus_pkg::slot_t     slot_i,
    input  pet_bus_pkg::ram_addr_t video_addr_i,
    output pet_bus_pkg::byte_t     video_data_o,
    output logic                   video_data_valid_o,
    output pet_bus_pkg::slot_t     video_slot_o,
    input  logic                   spi_valid_i,
    input  logic                   spi_we_i,
    input  pet_bus_pkg::ram_addr_t spi_addr_i,
    input  pet_bus_pkg::byte_t     spi_wdata_i,
    output logic                   spi_done_o,
    output pet_bus_pkg::byte_t     spi_rdata_o,
    ram_req_if.master              ram
);
    import pet_bus_pkg::*;

    logic   video_req;
    logic   spi_req;
    grant_t owner;      // Who the outstanding request belongs to
    slot_t  req_slot;   // Video slot of the outstanding fetch

    assign video_req = grant_valid_i && (grant_i == GRANT_VIDEO)
                       && (slot_i == SLOT_VIDEO_1 || slot_i == SLOT_VIDEO_3);
    assign spi_req   = grant_valid_i && (grant_i == GRANT_SPI) && spi_valid_i;

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            ram.valid <= 1'b0;
            owner     <= GRANT_VIDEO;
            req_slot  <= SLOT_VIDEO_1;
        end else begin
            ram.valid <= video_req || spi_req;  // One clock after the grant
            if (video_req) begin
                owner    <= GRANT_VIDEO;
                req_slot <= slot_i;
            end else if (spi_req) begin
                owner <= GRANT_SPI;
            end
        end
    end

    // VIDEO_3 fetches the odd byte of the pair
    always_ff @(posedge sys_clock_i) begin
        if (video_req) begin
            ram.we <= 1'b0;
            if (slot_i == SLOT_VIDEO_3) begin
                ram.addr <= video_addr_i + ram_addr_t'(1);
            end else begin
                ram.addr <= video_addr_i;
            end
        end else if (spi_req) begin
            ram.we    <= spi_we_i;
            ram.addr  <= spi_addr_i;
            ram.wdata <= spi_wdata_i;
        end
    end

    // Response steering, done comes two clocks after the grant
    assign video_data_o       = ram.rdata;
    assign video_data_valid_o = ram.done && (owner == GRANT_VIDEO);
    assign video_slot_o       = req_slot;

    assign spi_rdata_o = ram.rdata;
    assign spi_done_o  = ram.done && (owner == GRANT_SPI);

endmodule

// ==== ram_ctrl.sv ====
// On-chip byte RAM shared by the request port and the CPU
// CPU slots carry no grant, so the CPU strobe and a request never meet
// Reads are registered, contents are undefined after power-up
`timescale 1ns/100ps
`include "pet_bus_cfg.svh"

module ram_ctrl (
    input  logic                   sys_clock_i,
    input  logic                   reset_i,
    ram_req_if.slave               ram,
    input  logic                   cpu_data_strobe_i,
    input  pet_bus_pkg::ram_addr_t cpu_addr_i,
    input  logic                   cpu_we_i,
    input  pet_bus_pkg::byte_t     cpu_wdata_i,
    output pet_bus_pkg::byte_t     cpu_rdata_o,
    output logic                   cpu_rdata_valid_o
);
    import pet_bus_pkg::*;

    byte_t     mem [2**`PET_RAM_ADDR_BITS];
    logic      access;
    ram_addr_t addr;
    logic      we;
    byte_t     wdata;
    byte_t     rdata_q;

    // Single array port, CPU side selected at the strobe
    assign access = cpu_data_strobe_i || ram.valid;
    assign addr   = cpu_data_strobe_i ? cpu_addr_i  : ram.addr;
    assign we     = cpu_data_strobe_i ? cpu_we_i    : ram.we;
    assign wdata  = cpu_data_strobe_i ? cpu_wdata_i : ram.wdata;

    always_ff @(posedge sys_clock_i) begin
        if (access) begin
            if (we) begin
                mem[addr] <= wdata;
            end else if (cpu_data_strobe_i) begin
                cpu_rdata_o <= mem[addr];  // Held until the next CPU read
            end else begin
                rdata_q <= mem[addr];
            end
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            ram.done          <= 1'b0;
            cpu_rdata_valid_o <= 1'b0;
        end else begin
            ram.done          <= ram.valid;
            cpu_rdata_valid_o <= cpu_data_strobe_i && !cpu_we_i;
        end
    end

    assign ram.rdata = rdata_q;

endmodule

// ==== video_fetch.sv ====
// Screen fetch and pixel shifters for 40- and 80-column modes
// Each bus cycle shows the byte pair at the screen address, which then steps by 2
// The address counter wraps at the end of the RAM, sync is not generated here
`timescale 1ns/100ps
`include "pet_bus_cfg.svh"

module video_fetch (
    input  logic                   sys_clock_i,
    input  logic                   reset_i,
    input  logic                   clk8_en_i,
    input  logic                   clk16_en_i,
    input  logic                   load_sr1_i,
    input  logic                   load_sr2_i,
    input  pet_bus_pkg::byte_t     video_data_i,
    input  logic                   video_data_valid_i,
    input  pet_bus_pkg::slot_t     video_slot_i,
    output pet_bus_pkg::ram_addr_t video_addr_o,
    input  logic                   video_80col_i,
    output logic                   video_pixel_o,
    output logic                   video_pixel_en_o
);
    import pet_bus_pkg::*;

    byte_t hold0;   // Byte from VIDEO_1
    byte_t hold1;   // Byte from VIDEO_3
    byte_t sr1;     // 40-column shifter
    byte_t sr2;     // 80-column shifter

    // Steps at CPU_1, after both fetches of the cycle are in
    always_ff @(posedge sys_clock_i) begin
        if (reset_i) begin
            video_addr_o <= `PET_VIDEO_BASE;
        end else if (load_sr1_i) begin
            video_addr_o <= video_addr_o + ram_addr_t'(2);
        end
    end

    always_ff @(posedge sys_clock_i) begin
        if (video_data_valid_i) begin
            if (video_slot_i == SLOT_VIDEO_3) begin
                hold1 <= video_data_i;
            end else begin
                hold0 <= video_data_i;
            end
        end
    end

    // 8 pixels per bus cycle, MSB first
    always_ff @(posedge sys_clock_i) begin
        if (load_sr1_i) begin
            sr1 <= hold0;
        end else if (clk8_en_i) begin
            sr1 <= {sr1[6:0], 1'b0};
        end
    end

    // Even byte loads at SPI_1, odd byte at CPU_1, 16 pixels per bus cycle
    always_ff @(posedge sys_clock_i) begin
        if (load_sr2_i) begin
            sr2 <= load_sr1_i ? hold1 : hold0;
        end else if (clk16_en_i) begin
            sr2 <= {sr2[6:0], 1'b0};
        end
    end

    assign video_pixel_o    = video_80col_i ? sr2[7] : sr1[7];
    assign video_pixel_en_o = video_80col_i ? clk16_en_i : clk8_en_i;

endmodule

// ==== pet_bus_top.sv ====
// PET bus-timing core top level
// SPI side is a parallel request port, spi_valid_i held until spi_done_o
// CPU address and data arrive on plain ports, sampled at the internal data strobe
`timescale 1ns/100ps

module pet_bus_top (
    input  logic                   sys_clock_i,
    input  logic                   reset_i,
    input  logic                   spi_valid_i,
    input  logic                   spi_we_i,
    input  pet_bus_pkg::ram_addr_t spi_addr_i,
    input  pet_bus_pkg::byte_t     spi_wdata_i,
    output logic                   spi_done_o,
    output pet_bus_pkg::byte_t     spi_rdata_o,
    input  pet_bus_pkg::ram_addr_t cpu_addr_i,
    input  logic                   cpu_we_i,
    input  pet_bus_pkg::byte_t     cpu_wdata_i,
    output pet_bus_pkg::byte_t     cpu_rdata_o,
    output logic                   cpu_rdata_valid_o,
    output logic                   cpu_be_o,
    output logic                   cpu_clock_o,
    input  logic                   video_80col_i,
    output logic                   video_pixel_o,
    output logic                   video_pixel_en_o
);
    import pet_bus_pkg::*;

    logic      clk16_en;
    logic      clk8_en;
    logic      cpu_data_strobe;
    logic      load_sr1;
    logic      load_sr2;
    slot_t     slot;
    grant_t    grant;
    logic      grant_valid;
    ram_addr_t video_addr;
    byte_t     video_data;
    logic      video_data_valid;
    slot_t     video_slot;

    ram_req_if ram_req ();

    timing timing_i (
        .sys_clock_i       (sys_clock_i),
        .reset_i           (reset_i),
        .clk16_en_o        (clk16_en),
        .clk8_en_o         (clk8_en),
        .cpu_be_o          (cpu_be_o),
        .cpu_clock_o       (cpu_clock_o),
        .cpu_data_strobe_o (cpu_data_strobe),
        .load_sr1_o        (load_sr1),
        .load_sr2_o        (load_sr2),
        .slot_o            (slot),
        .grant_o           (grant),
        .grant_valid_o     (grant_valid)
    );

    bus_arbiter bus_arbiter_i (
        .sys_clock_i        (sys_clock_i),
        .reset_i            (reset_i),
        .grant_i            (grant),
        .grant_valid_i      (grant_valid),
        .slot_i             (slot),
        .video_addr_i       (video_addr),
        .video_data_o       (video_data),
        .video_data_valid_o (video_data_valid),
        .video_slot_o       (video_slot),
        .spi_valid_i        (spi_valid_i),
        .spi_we_i           (spi_we_i),
        .spi_addr_i         (spi_addr_i),
        .spi_wdata_i        (spi_wdata_i),
        .spi_done_o         (spi_done_o),
        .spi_rdata_o        (spi_rdata_o),
        .ram                (ram_req.master)
    );

    ram_ctrl ram_ctrl_i (
        .sys_clock_i       (sys_clock_i),
        .reset_i           (reset_i),
        .ram               (ram_req.slave),
        .cpu_data_strobe_i (cpu_data_strobe),
        .cpu_addr_i        (cpu_addr_i),
        .cpu_we_i          (cpu_we_i),
        .cpu_wdata_i       (cpu_wdata_i),
        .cpu_rdata_o       (cpu_rdata_o),
        .cpu_rdata_valid_o (cpu_rdata_valid_o)
    );

    video_fetch video_fetch_i (
        .sys_clock_i        (sys_clock_i),
        .reset_i            (reset_i),
        .clk8_en_i          (clk8_en),
        .clk16_en_i         (clk16_en),
        .load_sr1_i         (load_sr1),
        .load_sr2_i         (load_sr2),
        .video_data_i       (video_data),
        .video_data_valid_i (video_data_valid),
        .video_slot_i       (video_slot),
        .video_addr_o       (video_addr),
        .video_80col_i      (video_80col_i),
        .video_pixel_o      (video_pixel_o),
        .video_pixel_en_o   (video_pixel_en_o)
    );

endmodule

// ==== tb_pet_bus_top.sv ====
// Testbench for the PET bus-timing core
// Outputs are sampled on the falling clock edge, inputs change on the rising edge
// Reset is applied once, so the bus cycle count seen here matches the video address steps
`timescale 1ns/100ps
`include "pet_bus_cfg.svh"

module tb_pet_bus_top;
    import pet_bus_pkg::*;

    localparam int BUS_CLOCKS    = 64;
    localparam int PHASE_WINDOWS = 4;
    localparam int SPI_OPS       = 32;
    localparam int CPU_OPS       = 16;
    localparam int FILL_BYTES    = 1 << `PET_RAM_ADDR_BITS;
    localparam int VIDEO_CYCLES  = 24;
    localparam int STRESS_OPS    = 40;
    localparam int SPI_WAIT_MAX  = 48;   // SPI slots lie 24 and 40 clocks apart, plus RAM latency
    localparam int SPI_DONE_MAX  = 39 + 2 + 1;  // Just missed SPI_2, next SPI_1, then to done
    localparam int SPI_OP_CLOCKS = SPI_WAIT_MAX + 2;
    localparam int CPU_OP_CLOCKS = 3 * BUS_CLOCKS;
    localparam int TEST_CLOCKS   = (PHASE_WINDOWS + 1) * BUS_CLOCKS
                                 + 2 * SPI_OPS * SPI_OP_CLOCKS
                                 + 2 * CPU_OPS * CPU_OP_CLOCKS + 4 * SPI_OP_CLOCKS
                                 + FILL_BYTES * SPI_OP_CLOCKS
                                 + 2 * (VIDEO_CYCLES + 4) * BUS_CLOCKS
                                 + STRESS_OPS * (SPI_OP_CLOCKS + 8) + 3 * BUS_CLOCKS;
    localparam int WATCHDOG_CLOCKS = TEST_CLOCKS + TEST_CLOCKS / 8 + 1000;

    logic      sys_clock_i;
    logic      reset_i;
    logic      spi_valid_i;
    logic      spi_we_i;
    ram_addr_t spi_addr_i;
    byte_t     spi_wdata_i;
    logic      spi_done_o;
    byte_t     spi_rdata_o;
    ram_addr_t cpu_addr_i;
    logic      cpu_we_i;
    byte_t     cpu_wdata_i;
    byte_t     cpu_rdata_o;
    logic      cpu_rdata_valid_o;
    logic      cpu_be_o;
    logic      cpu_clock_o;
    logic      video_80col_i;
    logic      video_pixel_o;
    logic      video_pixel_en_o;

    byte_t     shadow [FILL_BYTES];  // Reference copy of the RAM
    ram_addr_t addr_q [$];           // Addresses known to hold data
    int        error_count;
    int        test_errors_base;
    int        tests_run;
    int        tests_failed;
    int        done_total;
    int        bus_count;            // BE rises since reset, one per bus cycle
    int        cur_bus;
    int        pix_idx;
    int        video_run;
    logic      video_active;
    int        pixels_checked;
    logic      be_last;
    logic      exp_pixel;

    pet_bus_top dut_i (.*);

    initial begin
        sys_clock_i = 1'b0;
        forever #4 sys_clock_i = ~sys_clock_i;
    end

    initial begin
        repeat (WATCHDOG_CLOCKS) @(posedge sys_clock_i);
        $display("Timeout: the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
        $display(">>> FAIL");
        $finish;
    end

    // Smallest whole number of system clocks that covers time_ns
    function automatic int clocks_for_ns(input int time_ns);
        int n;
        n = 0;
        while (n * 1000 < time_ns * `PET_SYS_CLOCK_MHZ) begin
            n++;
        end
        return n;
    endfunction

    // Expected pixel for enable pix after the CPU_1 load of bus cycle bus_idx
    function automatic logic pixel_ref(input int bus_idx, input int pix, input logic mode80);
        ram_addr_t base_addr;
        ram_addr_t a;
        byte_t     b;
        base_addr = ram_addr_t'(int'(`PET_VIDEO_BASE) + 2 * bus_idx);
        if (mode80) begin
            a = ram_addr_t'(int'(base_addr) + 1 + pix / 8);  // Odd byte, then next even byte
        end else begin
            a = base_addr;
        end
        b = shadow[a];
        return b[7 - pix % 8];
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        error_count++;
    endtask

    task automatic end_test(input string name);
        int    errs;
        string verdict;
        errs = error_count - test_errors_base;
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
            verdict = "failed";
        end else begin
            verdict = "ok";
        end
        $display("%s: %s, %0d errors", name, verdict, errs);
        test_errors_base = error_count;
    endtask

    // Counts every done pulse to catch lost or duplicate responses
    always @(negedge sys_clock_i) begin
        if (!reset_i && spi_done_o) begin
            done_total++;
        end
    end

    // Pixel comparison, the BE rise marks the CPU_1 shifter load
    always @(negedge sys_clock_i) begin
        if (!reset_i) begin
            if (video_active && video_pixel_en_o) begin
                exp_pixel = pixel_ref(cur_bus, pix_idx, video_80col_i);
                if (video_pixel_o !== exp_pixel) begin
                    report_mismatch($sformatf("pixel %0d of bus cycle %0d is %b, expected %b",
                                              pix_idx, cur_bus, video_pixel_o, exp_pixel));
                end
                pixels_checked++;
                pix_idx++;
            end
            if (cpu_be_o && !be_last) begin
                cur_bus = bus_count;
                bus_count++;
                pix_idx = 0;
                video_active = video_run > 0;
                if (video_run > 0) begin
                    video_run--;
                end
            end
            be_last = cpu_be_o;
        end
    end

    task automatic spi_access(input logic we, input ram_addr_t addr, input byte_t wdata,
                              output int waited);
        logic  seen;
        byte_t rdata;
        seen   = 1'b0;
        waited = 0;
        rdata  = '0;
        @(posedge sys_clock_i);
        spi_valid_i <= 1'b1;
        spi_we_i    <= we;
        spi_addr_i  <= addr;
        spi_wdata_i <= wdata;
        while (!seen && waited < SPI_WAIT_MAX) begin
            @(negedge sys_clock_i);
            waited++;
            if (spi_done_o) begin
                seen  = 1'b1;
                rdata = spi_rdata_o;
            end
        end
        @(posedge sys_clock_i);
        spi_valid_i <= 1'b0;
        if (!seen) begin
            report_problem($sformatf("SPI request at %h got no done pulse", addr));
        end else if (we) begin
            shadow[addr] = wdata;
        end else if (rdata !== shadow[addr]) begin
            report_mismatch($sformatf("SPI read at %h gave %h, expected %h",
                                      addr, rdata, shadow[addr]));
        end
    endtask

    // One CPU access in the next full bus-enable window
    task automatic cpu_access(input logic we, input ram_addr_t addr, input byte_t wdata);
        int    pulses;
        byte_t rdata;
        pulses = 0;
        rdata  = '0;
        @(negedge sys_clock_i);
        while (cpu_be_o) @(negedge sys_clock_i);
        @(posedge sys_clock_i);
        cpu_addr_i  <= addr;
        cpu_we_i    <= we;
        cpu_wdata_i <= wdata;
        @(negedge sys_clock_i);
        while (!cpu_be_o) begin
            if (cpu_rdata_valid_o) begin
                pulses++;
            end
            @(negedge sys_clock_i);
        end
        while (cpu_be_o) begin
            if (cpu_rdata_valid_o) begin
                pulses++;
                rdata = cpu_rdata_o;
            end
            @(negedge sys_clock_i);
        end
        if (we) begin
            shadow[addr] = wdata;
            if (pulses != 0) begin
                report_mismatch($sformatf("cpu_rdata_valid_o pulsed %0d times on a write", pulses));
            end
        end else if (pulses != 1) begin
            report_mismatch($sformatf("cpu_rdata_valid_o pulsed %0d times on a read", pulses));
        end else if (rdata !== shadow[addr]) begin
            report_mismatch($sformatf("CPU read at %h gave %h, expected %h",
                                      addr, rdata, shadow[addr]));
        end
    endtask

    task automatic check_cpu_phase();
        int   t;
        int   windows;
        int   clk_pulses;
        int   be_rise_t;
        int   clk_rise_t;
        int   clk_fall_t;
        int   prev_rise_t;
        logic be_q;
        logic clk_q;
        t = 0;
        windows = 0;
        clk_pulses = 0;
        be_rise_t = 0;
        clk_rise_t = 0;
        clk_fall_t = 0;
        prev_rise_t = -1;
        be_q = 1'b0;
        clk_q = 1'b0;
        @(negedge sys_clock_i);
        if (cpu_be_o !== 1'b0 || cpu_clock_o !== 1'b0) begin
            report_mismatch("cpu_be_o or cpu_clock_o not low after reset");
        end
        while (windows < PHASE_WINDOWS) begin
            @(negedge sys_clock_i);
            t++;
            if (cpu_be_o && !be_q) begin
                if (prev_rise_t >= 0 && t - prev_rise_t != BUS_CLOCKS) begin
                    report_mismatch($sformatf("BE period %0d clocks", t - prev_rise_t));
                end
                prev_rise_t = t;
                be_rise_t = t;
                clk_pulses = 0;
            end
            if (cpu_clock_o && !clk_q) begin
                clk_rise_t = t;
                clk_pulses++;
                if (!cpu_be_o) begin
                    report_mismatch("CPU clock rose outside the bus-enable window");
                end
            end
            if (!cpu_clock_o && clk_q) begin
                clk_fall_t = t;
            end
            if (!cpu_be_o && be_q) begin
                windows++;
                if (clk_pulses != 1
                    || clk_rise_t - be_rise_t != clocks_for_ns(`PET_CPU_T_BVD + `PET_IOTX_T) + 1
                    || clk_fall_t - clk_rise_t != clocks_for_ns(`PET_CPU_T_PWH) + 1
                    || t - clk_fall_t != clocks_for_ns(`PET_CPU_T_DHX) + 1) begin
                    report_mismatch($sformatf("CPU phase %0d pulses, offsets %0d/%0d/%0d",
                                              clk_pulses, clk_rise_t - be_rise_t,
                                              clk_fall_t - clk_rise_t, t - clk_fall_t));
                end
            end
            be_q = cpu_be_o;
            clk_q = cpu_clock_o;
        end
    endtask

    task automatic run_video(input logic mode80);
        @(posedge sys_clock_i);
        video_80col_i <= mode80;
        repeat (2 * BUS_CLOCKS) @(posedge sys_clock_i);  // Let the shifters refill
        pixels_checked = 0;
        video_run = VIDEO_CYCLES;
        @(negedge sys_clock_i);
        while (video_run != 0 || video_active) @(negedge sys_clock_i);
        if (pixels_checked != VIDEO_CYCLES * (mode80 ? 16 : 8)) begin
            report_mismatch($sformatf("%0d pixel enables seen", pixels_checked));
        end
    endtask

    initial begin
        ram_addr_t a;
        int        waited;
        int        max_wait;
        int        done_start;
        void'($urandom(32'h3b80_8db8));
        reset_i = 1'b1;
        spi_valid_i = 1'b0;
        spi_we_i = 1'b0;
        spi_addr_i = '0;
        spi_wdata_i = '0;
        cpu_addr_i = '0;
        cpu_we_i = 1'b0;
        cpu_wdata_i = '0;
        video_80col_i = 1'b0;
        error_count = 0;
        test_errors_base = 0;
        tests_run = 0;
        tests_failed = 0;
        done_total = 0;
        bus_count = 0;
        cur_bus = 0;
        pix_idx = 0;
        video_run = 0;
        video_active = 1'b0;
        pixels_checked = 0;
        be_last = 1'b0;
        repeat (2) @(posedge sys_clock_i);
        reset_i <= 1'b0;

        check_cpu_phase();
        end_test("cpu bus phase");

        for (int i = 0; i < SPI_OPS; i++) begin
            a = ram_addr_t'($urandom);
            spi_access(1'b1, a, byte_t'($urandom), waited);
            addr_q.push_back(a);
        end
        foreach (addr_q[i]) begin
            spi_access(1'b0, addr_q[i], '0, waited);
        end
        end_test("spi write and read");

        for (int i = 0; i < CPU_OPS; i++) begin
            a = ram_addr_t'($urandom);
            cpu_access(1'b1, a, byte_t'($urandom));
            addr_q.push_back(a);
        end
        for (int i = 0; i < CPU_OPS; i++) begin
            cpu_access(1'b0, addr_q[$urandom % addr_q.size()], '0);
        end
        for (int i = 0; i < 4; i++) begin
            spi_access(1'b0, addr_q[addr_q.size() - 1 - i], '0, waited);
        end
        @(posedge sys_clock_i);
        cpu_we_i <= 1'b0;   // Later strobes only read
        end_test("cpu write and read");

        for (int i = 0; i < FILL_BYTES; i++) begin
            a = ram_addr_t'(i);
            spi_access(1'b1, a, byte_t'(a) ^ byte_t'(a >> 4) ^ 8'h3c, waited);
        end
        run_video(1'b0);
        end_test("video 40 columns");

        run_video(1'b1);
        end_test("video 80 columns");

        max_wait = 0;
        done_start = done_total;
        for (int i = 0; i < STRESS_OPS; i++) begin
            repeat ($urandom % 8) @(posedge sys_clock_i);
            spi_access(1'($urandom), ram_addr_t'($urandom), byte_t'($urandom), waited);
            if (waited > max_wait) begin
                max_wait = waited;
            end
        end
        repeat (2 * BUS_CLOCKS) @(posedge sys_clock_i);
        if (done_total - done_start != STRESS_OPS) begin
            report_mismatch($sformatf("%0d done pulses for %0d requests",
                                      done_total - done_start, STRESS_OPS));
        end
        if (max_wait > SPI_DONE_MAX) begin
            report_mismatch($sformatf("longest SPI wait %0d clocks, limit %0d",
                                      max_wait, SPI_DONE_MAX));
        end
        end_test("spi under video traffic");

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== pet_bus_top.f ====
+incdir+.
pet_bus_pkg.sv
ram_req_if.sv
timing.sv
bus_arbiter.sv
ram_ctrl.sv
video_fetch.sv
pet_bus_top.sv
tb_pet_bus_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the testbench with Verilator, status follows the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_pet_bus_top -f pet_bus_top.f -o sim_pet_bus || exit 1
out=$(./obj_dir/sim_pet_bus)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '>>> PASS' && echo "simulation passed" && exit 0 || {
    echo "simulation did not pass"
    exit 1
}
